/* logic/ldpc_code_pkg.sv */
// (8,4) extended hamming code geometry
// parity check matrix as one column mask per row

package ldpc_code_pkg;

  localparam int code_n = 8;
  localparam int code_m = 4;
  localparam int row_w  = 2;

  // check row index
  typedef logic [row_w-1:0]  hb_row_t;

  // one hard bit per column with bit 0 at column 0
  typedef logic [code_n-1:0] bits_t;

  // row 3 is the overall parity row
  localparam bits_t h_mask [code_m] = '{
    8'b0001_0111,
    8'b0010_1011,
    8'b0100_1101,
    8'b1111_1111
  };

endpackage

/* logic/ldpc_dec_cnode.sv */
// one-row layered normalized min-sum update
// two minimum search and sign product over the masked columns

`timescale 1ns/1ns

module ldpc_dec_cnode (
  input  ldpc_code_pkg::hb_row_t row,
  input  ldpc_dec_pkg::row_msg_t total,
  input  ldpc_dec_pkg::row_msg_t old_msg,
  output ldpc_dec_pkg::row_msg_t new_total,
  output ldpc_dec_pkg::row_msg_t new_msg
);

  import ldpc_code_pkg::*;
  import ldpc_dec_pkg::*;

  bits_t                    mask;
  // v2c needs one guard bit over the node width
  logic signed [node_w:0]   v2c     [code_n];
  logic        [node_w-1:0] mag     [code_n];
  logic        [node_w-1:0] min1;
  logic        [node_w-1:0] min2;
  bits_t                    min_sel;
  logic                     sgn_prod;
  logic        [node_w-1:0] sel_mag [code_n];
  logic        [node_w+2:0] scaled  [code_n];
  node_t                    msg     [code_n];
  logic signed [node_w+1:0] sum     [code_n];

  assign mask = h_mask[row];

  //--------------------------------------------------------------------------
  // v2c, magnitudes, two minimums and sign product
  //--------------------------------------------------------------------------

  always_comb begin
    min1     = '1;
    min2     = '1;
    min_sel  = '0;
    sgn_prod = 1'b0;
    for (int i = 0; i < code_n; i++) begin
      v2c[i] = $signed(total[i]) - $signed(old_msg[i]);
      mag[i] = v2c[i][node_w] ? node_w'(-v2c[i]) : node_w'(v2c[i]);
      if (mask[i]) begin
        sgn_prod = sgn_prod ^ v2c[i][node_w];
        if (mag[i] < min1) begin
          min2       = min1;
          min1       = mag[i];
          min_sel    = '0;
          min_sel[i] = 1'b1;
        end
        else if (mag[i] < min2) begin
          min2 = mag[i];
        end
      end
    end
  end

  //--------------------------------------------------------------------------
  // new messages and saturated totals
  //--------------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < code_n; i++) begin
      // the minimum column sees the second minimum
      sel_mag[i] = min_sel[i] ? min2 : min1;
      scaled[i]  = ({3'b000, sel_mag[i]} * {7'd0, cnorm_mul}) >> cnorm_shift;
      if (scaled[i] > node_max)
        msg[i] = node_t'(node_max);
      else
        msg[i] = node_t'(scaled[i]);
      // extrinsic sign with own sign taken out of the product
      if (sgn_prod ^ v2c[i][node_w])
        msg[i] = -msg[i];
      sum[i] = v2c[i] + msg[i];
      // columns outside the row pass through
      if (!mask[i]) begin
        new_total[i] = total[i];
        new_msg[i]   = '0;
      end
      else begin
        if (sum[i] > node_max)
          new_total[i] = node_t'(node_max);
        else if (sum[i] < -node_max)
          new_total[i] = node_t'(-node_max);
        else
          new_total[i] = node_t'(sum[i]);
        new_msg[i] = msg[i];
      end
    end
  end

endmodule

/* logic/ldpc_dec_ctrl.sv */
// decoder frame FSM
// row and iteration counters, early stop decision
// per-frame tag, iteration count and mode registers

`timescale 1ns/1ns

module ldpc_dec_ctrl (
  input  logic                             iclk,
  input  logic                             ireset,
  input  logic                             start,
  input  logic [ldpc_dec_pkg::niter_w-1:0] niter,
  input  logic                             fmode,
  input  logic [ldpc_dec_pkg::tag_w-1:0]   tag,
  input  logic                             syn_zero,
  output logic                             busy,
  output logic                             load,
  output logic                             row_val,
  output ldpc_code_pkg::hb_row_t           row,
  output logic                             done,
  output logic [ldpc_dec_pkg::tag_w-1:0]   done_tag
);

  import ldpc_code_pkg::*;
  import ldpc_dec_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_run,
    st_check,
    st_flush
  } state_t;

  state_t             state;
  logic [niter_w-1:0] niter_q;
  logic [niter_w-1:0] iter_cnt;
  logic               fmode_q;
  logic [tag_w-1:0]   tag_q;
  // one based number of the iteration in progress
  logic [niter_w:0]   iter_num;
  logic               stop;

  //--------------------------------------------------------------------------
  // stop decision in the check cycle
  //--------------------------------------------------------------------------

  assign iter_num = {1'b0, iter_cnt} + 1'b1;
  // niter of 0 still runs one iteration
  assign stop     = (iter_num >= {1'b0, niter_q}) | (fmode_q & syn_zero);

  assign busy     = (state != st_idle);
  assign load     = (state == st_load);
  assign row_val  = (state == st_run);
  assign done     = (state == st_check) & stop;
  assign done_tag = tag_q;

  //--------------------------------------------------------------------------
  // frame FSM
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= st_idle;
      row      <= '0;
      iter_cnt <= '0;
    end
    else begin
      case (state)
        st_idle : begin
          if (start)
            state <= st_load;
        end
        st_load : begin
          state    <= st_run;
          row      <= '0;
          iter_cnt <= '0;
        end
        st_run : begin
          // row wraps to 0 after the last row
          row <= row + 1'b1;
          if (row == hb_row_t'(code_m - 1))
            state <= st_check;
        end
        st_check : begin
          if (stop) begin
            state <= st_flush;
          end
          else begin
            state    <= st_run;
            iter_cnt <= iter_cnt + 1'b1;
          end
        end
        // out_val cycle with busy still high
        st_flush : state <= st_idle;
        default  : state <= st_idle;
      endcase
    end
  end

  // request fields held for the whole frame
  always_ff @(posedge iclk) begin
    if ((state == st_idle) & start) begin
      niter_q <= niter;
      fmode_q <= fmode;
      tag_q   <= tag;
    end
  end

endmodule

/* logic/ldpc_dec_node_mem.sv */
// column total registers
// per-row check-to-variable message store read at the current row

`timescale 1ns/1ns

module ldpc_dec_node_mem (
  input  logic                                           iclk,
  input  logic                                           ireset,
  input  logic                                           load,
  input  ldpc_dec_pkg::llr_t [ldpc_code_pkg::code_n-1:0] llr,
  input  logic                                           row_val,
  input  ldpc_code_pkg::hb_row_t                         row,
  input  ldpc_dec_pkg::row_msg_t                         new_total,
  input  ldpc_dec_pkg::row_msg_t                         new_msg,
  output ldpc_dec_pkg::row_msg_t                         total,
  output ldpc_dec_pkg::row_msg_t                         old_msg
);

  import ldpc_code_pkg::*;
  import ldpc_dec_pkg::*;

  // one message word per check row
  row_msg_t msg_mem [code_m];

  // combinational read for the row being updated
  assign old_msg = msg_mem[row];

  // totals start from the sign extended channel llr
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      total <= '0;
    end
    else if (load) begin
      for (int i = 0; i < code_n; i++)
        total[i] <= node_t'(llr[i]);
    end
    else if (row_val) begin
      total <= new_total;
    end
  end

  // messages cleared per frame and written once per row
  always_ff @(posedge iclk) begin
    if (load) begin
      for (int r = 0; r < code_m; r++)
        msg_mem[r] <= '0;
    end
    else if (row_val) begin
      msg_mem[row] <= new_msg;
    end
  end

endmodule

/* logic/ldpc_dec_out.sv */
// hard decision and syndrome of the current totals
// channel hard bits, error count and result registers

`timescale 1ns/1ns

module ldpc_dec_out (
  input  logic                                           iclk,
  input  logic                                           ireset,
  input  ldpc_dec_pkg::row_msg_t                         total,
  input  ldpc_dec_pkg::llr_t [ldpc_code_pkg::code_n-1:0] llr,
  input  logic                                           done,
  input  logic [ldpc_dec_pkg::tag_w-1:0]                 done_tag,
  output logic                                           syn_zero,
  output logic                                           out_val,
  output ldpc_dec_pkg::dec_out_t                         dec_out
);

  import ldpc_code_pkg::*;
  import ldpc_dec_pkg::*;

  bits_t             hard;
  bits_t             chan_bits;
  logic [code_m-1:0] syn;
  logic [err_w-1:0]  err_cnt;
  row_msg_t          total_q;
  logic              busy;
  logic              load_edge;

  //--------------------------------------------------------------------------
  // hard bits, syndrome, error count
  //--------------------------------------------------------------------------

  always_comb begin
    err_cnt = '0;
    for (int i = 0; i < code_n; i++) begin
      hard[i] = total[i][node_w-1];
      err_cnt = err_cnt + err_w'(hard[i] ^ chan_bits[i]);
    end
    for (int r = 0; r < code_m; r++)
      syn[r] = ^(hard & h_mask[r]);
  end

  assign syn_zero = (syn == '0);

  // first change of the totals after a result marks the new frame load
  assign load_edge = !busy & (total != total_q);

  //--------------------------------------------------------------------------
  // frame tracking and result registers
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy    <= 1'b0;
      out_val <= 1'b0;
      total_q <= '0;
    end
    else begin
      out_val <= done;
      total_q <= total;
      if (done)
        busy <= 1'b0;
      else if (load_edge)
        busy <= 1'b1;
    end
  end

  always_ff @(posedge iclk) begin
    // last sample is the llr seen on load
    if (!busy & !load_edge) begin
      for (int i = 0; i < code_n; i++)
        chan_bits[i] <= llr[i][llr_w-1];
    end
    if (done) begin
      dec_out.bits    <= hard;
      dec_out.tag     <= done_tag;
      dec_out.err     <= err_cnt;
      dec_out.decfail <= !syn_zero;
    end
  end

endmodule

/* logic/ldpc_dec_pkg.sv */
// decoder datapath widths and saturation limits
// min-sum normalization constants
// frame request, frame result and row message types

package ldpc_dec_pkg;

  // positive channel llr means bit 0
  localparam int llr_w   = 5;
  // node totals and check messages
  localparam int node_w  = 7;
  localparam int node_max = 63;

  // check message scaling by 7/8
  localparam logic [2:0] cnorm_mul   = 3'd7;
  localparam int         cnorm_shift = 3;

  localparam int tag_w   = 4;
  localparam int niter_w = 4;
  localparam int err_w   = 4;

  typedef logic signed [llr_w-1:0]  llr_t;
  typedef logic signed [node_w-1:0] node_t;

  // one value per column for totals and messages
  typedef node_t [ldpc_code_pkg::code_n-1:0] row_msg_t;

  // frame request
  typedef struct packed {
    llr_t [ldpc_code_pkg::code_n-1:0] llr;
    logic [tag_w-1:0]                 tag;
    logic [niter_w-1:0]               niter;
    logic                             fmode;
  } dec_in_t;

  // frame result
  typedef struct packed {
    ldpc_code_pkg::bits_t bits;
    logic [tag_w-1:0]     tag;
    logic [err_w-1:0]     err;
    logic                 decfail;
  } dec_out_t;

endpackage

/* logic/ldpc_dec_top.sv */
// layered min-sum ldpc decoder top level
// controller, node memory, check node unit and output block

`timescale 1ns/1ns

module ldpc_dec_top (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   start,
  input  ldpc_dec_pkg::dec_in_t  dec_in,
  output logic                   busy,
  output logic                   out_val,
  output ldpc_dec_pkg::dec_out_t dec_out
);

  import ldpc_code_pkg::*;
  import ldpc_dec_pkg::*;

  //--------------------------------------------------------------------------
  // internal wires
  //--------------------------------------------------------------------------

  logic             load;
  logic             row_val;
  hb_row_t          row;
  logic             done;
  logic [tag_w-1:0] done_tag;
  logic             syn_zero;
  // totals and messages around the check node loop
  row_msg_t         total;
  row_msg_t         old_msg;
  row_msg_t         new_total;
  row_msg_t         new_msg;

  //--------------------------------------------------------------------------
  // blocks
  //--------------------------------------------------------------------------

  ldpc_dec_ctrl ctrl_inst (
    .iclk     (iclk),
    .ireset   (ireset),
    .start    (start),
    .niter    (dec_in.niter),
    .fmode    (dec_in.fmode),
    .tag      (dec_in.tag),
    .syn_zero (syn_zero),
    .busy     (busy),
    .load     (load),
    .row_val  (row_val),
    .row      (row),
    .done     (done),
    .done_tag (done_tag)
  );

  // channel llrs are taken on load
  ldpc_dec_node_mem node_mem_inst (
    .iclk      (iclk),
    .ireset    (ireset),
    .load      (load),
    .llr       (dec_in.llr),
    .row_val   (row_val),
    .row       (row),
    .new_total (new_total),
    .new_msg   (new_msg),
    .total     (total),
    .old_msg   (old_msg)
  );

  ldpc_dec_cnode cnode_inst (
    .row       (row),
    .total     (total),
    .old_msg   (old_msg),
    .new_total (new_total),
    .new_msg   (new_msg)
  );

  ldpc_dec_out out_inst (
    .iclk     (iclk),
    .ireset   (ireset),
    .total    (total),
    .llr      (dec_in.llr),
    .done     (done),
    .done_tag (done_tag),
    .syn_zero (syn_zero),
    .out_val  (out_val),
    .dec_out  (dec_out)
  );

endmodule

/* sim/ldpc_dec_cases.txt */
# columns: llr0 .. llr7 (signed, column 0 first), niter, fmode, expected bits
# expected bits run from bit 7 down to bit 0, x means check the rules only
15 15 15 15 15 15 15 15 2 1 00000000
-15 15 15 15 -15 -15 -15 15 3 1 01110001
-15 -15 -15 -15 -15 -15 -15 -15 1 1 11111111
15 15 15 -15 15 -15 -15 -15 3 0 11101000
-15 -15 15 15 15 15 -15 -15 0 0 11000011
-2 15 15 15 15 15 15 15 4 0 00000000
-15 -15 15 15 15 15 -15 2 4 0 11000011
15 -15 -2 15 -15 -15 15 -15 4 1 10110010
15 15 -15 15 -15 -2 -15 -15 4 0 11010100
3 -4 1 -1 5 -2 0 -6 5 0 x
-1 1 -1 1 -1 1 -1 1 7 1 x
2 2 -3 -3 4 -4 1 -1 3 0 x
-15 15 -15 15 0 0 -7 7 15 0 x
0 0 0 0 0 0 0 0 1 0 x
6 -5 -9 3 -1 8 -2 -4 2 1 x

/* sim/ldpc_dec_tb.sv */
// testbench for the layered min-sum ldpc decoder
// case file reader, lfsr for idle gaps and tags, frame driver
// rule checks on every result, cycle counter timeout

`timescale 1ns/1ns

module ldpc_dec_tb;

  import ldpc_code_pkg::*;
  import ldpc_dec_pkg::*;

  localparam int clk_half     = 2;
  localparam int reset_cycles = 10;
  localparam int max_cases    = 64;
  // worst frame is start, 16 iterations, idle gap and slack
  localparam int frame_cycles = 2 + 5 * 16 + 8;

  // one line of the case file
  typedef struct packed {
    llr_t [code_n-1:0]  llr;
    logic [niter_w-1:0] niter;
    logic               fmode;
    logic               has_exp;
    bits_t              exp_bits;
  } case_t;

  logic        iclk;
  logic        ireset;
  logic        start;
  dec_in_t     dec_in;
  logic        busy;
  logic        out_val;
  dec_out_t    dec_out;

  case_t       cases [max_cases];
  int          n_cases;
  int          n_results;
  int          err_count;
  int          cycle_cnt;
  int          cycle_limit;
  logic [15:0] lfsr_state;

  ldpc_dec_top ldpc_dec_top_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .start   (start),
    .dec_in  (dec_in),
    .busy    (busy),
    .out_val (out_val),
    .dec_out (dec_out)
  );

  //--------------------------------------------------------------------------
  // clock, timeout, result counter
  //--------------------------------------------------------------------------

  initial begin
    iclk = 1'b0;
    forever #clk_half iclk = ~iclk;
  end

  always @(posedge iclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the decoder gave no result within %0d cycles", cycle_limit);
      stop_on_error();
    end
  end

  // counts every result strobe whether expected or not
  always @(negedge iclk) begin
    if (!ireset && out_val)
      n_results <= n_results + 1;
  end

  //--------------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------------

  // 16 bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit
  task automatic take_random(input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = (value << 1) | lfsr_state[0];
    end
  endtask

  // even parity over each row of the check matrix
  function automatic logic [code_m-1:0] syndrome_of(input bits_t b);
    logic [code_m-1:0] s;
    for (int r = 0; r < code_m; r++)
      s[r] = ^(b & h_mask[r]);
    return s;
  endfunction

  function automatic int count_ones(input bits_t b);
    int n;
    n = 0;
    for (int i = 0; i < code_n; i++)
      n += b[i];
    return n;
  endfunction

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input int got, input int exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  //--------------------------------------------------------------------------
  // case file
  //--------------------------------------------------------------------------

  task automatic read_cases();
    int               fd;
    int               nf;
    int               lv [code_n];
    int               niter_v;
    int               fmode_v;
    logic [8*8-1:0]   tok;
    logic [8*160-1:0] line_buf;
    n_cases = 0;
    fd = $fopen("sim/ldpc_dec_cases.txt", "r");
    if (fd == 0) begin
      $display("the case file sim/ldpc_dec_cases.txt could not be opened");
      stop_on_error();
    end
    else begin
      while (!$feof(fd) && n_cases < max_cases) begin
        line_buf = '0;
        tok      = '0;
        nf = $fgets(line_buf, fd);
        nf = $sscanf(line_buf, "%d %d %d %d %d %d %d %d %d %d %s",
                     lv[0], lv[1], lv[2], lv[3], lv[4], lv[5], lv[6], lv[7],
                     niter_v, fmode_v, tok);
        // comment and blank lines give fewer fields
        if (nf == 11) begin
          for (int i = 0; i < code_n; i++) begin
            cases[n_cases].llr[i] = llr_t'(lv[i]);
            // last character of the token is bit 0
            cases[n_cases].exp_bits[i] = (tok[8*i +: 8] == "1");
          end
          cases[n_cases].niter   = niter_v[niter_w-1:0];
          cases[n_cases].fmode   = fmode_v[0];
          cases[n_cases].has_exp = (tok != "x");
          n_cases++;
        end
      end
      $fclose(fd);
    end
  endtask

  //--------------------------------------------------------------------------
  // one frame driven on the rising edge and sampled on the falling edge
  //--------------------------------------------------------------------------

  task automatic run_frame(input int k);
    case_t   c;
    dec_in_t req;
    bits_t   chan;
    int      gap;
    int      tag;
    int      extra;
    int      lat;
    int      bound;
    c = cases[k];
    take_random(3, gap);
    take_random(tag_w, tag);
    take_random(1, extra);
    for (int i = 0; i < code_n; i++)
      chan[i] = c.llr[i][llr_w-1];
    req.llr   = c.llr;
    req.tag   = tag[tag_w-1:0];
    req.niter = c.niter;
    req.fmode = c.fmode;
    // fmode clear runs max(niter, 1) iterations of 5 cycles
    bound = 2 + 5 * ((c.niter == 0) ? 1 : c.niter);
    repeat (gap) @(posedge iclk);
    @(posedge iclk);
    start  <= 1'b1;
    dec_in <= req;
    lat = 0;
    @(posedge iclk);
    start <= 1'b0;
    lat++;
    // second request while busy carries another tag
    if (extra != 0) begin
      @(posedge iclk);
      start      <= 1'b1;
      dec_in.tag <= ~req.tag;
      lat++;
      @(posedge iclk);
      start <= 1'b0;
      lat++;
    end
    @(negedge iclk);
    check_value(busy, 1, $sformatf("case %0d busy during frame", k));
    while (!out_val) begin
      @(posedge iclk);
      lat++;
      @(negedge iclk);
    end
    if (c.has_exp)
      check_value(dec_out.bits, c.exp_bits, $sformatf("case %0d hard bits", k));
    check_value(dec_out.decfail, syndrome_of(dec_out.bits) != 0,
                $sformatf("case %0d decfail", k));
    check_value(dec_out.err, count_ones(dec_out.bits ^ chan),
                $sformatf("case %0d error count", k));
    check_value(dec_out.tag, req.tag, $sformatf("case %0d tag", k));
    if (!c.fmode)
      check_value(lat, bound, $sformatf("case %0d latency", k));
    else
      check_value(lat <= bound, 1, $sformatf("case %0d latency bound", k));
  endtask

  //--------------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------------

  initial begin
    ireset      = 1'b1;
    start       = 1'b0;
    dec_in      = '0;
    n_results   = 0;
    err_count   = 0;
    cycle_cnt   = 0;
    lfsr_state  = 16'd50;
    read_cases();
    cycle_limit = n_cases * frame_cycles + 2 * reset_cycles;
    repeat (reset_cycles) @(posedge iclk);
    ireset <= 1'b0;
    for (int k = 0; k < n_cases; k++)
      run_frame(k);
    // room for a stray result after the last frame
    repeat (8) @(posedge iclk);
    check_value(n_cases > 0, 1, "cases read from the case file");
    check_value(n_results, n_cases, "number of results");
    if (err_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end
    else begin
      stop_on_error();
    end
  end

endmodule

/* sim/ldpc_dec_tb_assert.sv */
// concurrent checks on the decoder top level protocol
// bound into every ldpc_dec_top instance

`timescale 1ns/1ns

module ldpc_dec_tb_assert (
  input logic iclk,
  input logic ireset,
  input logic busy,
  input logic out_val
);

  // result strobe is a single cycle pulse
  out_val_pulse : assert property (
    @(posedge iclk) disable iff (ireset) out_val |=> !out_val
  ) else $error("out_val stayed high for more than one cycle");

  // no frame in flight right after reset
  busy_after_reset : assert property (
    @(posedge iclk) $fell(ireset) |-> !busy
  ) else $error("busy was high right after reset");

  // results only inside a frame
  out_val_in_frame : assert property (
    @(posedge iclk) disable iff (ireset) out_val |-> busy
  ) else $error("out_val came while busy was low");

endmodule

bind ldpc_dec_top ldpc_dec_tb_assert ldpc_dec_tb_assert_inst (
  .iclk    (iclk),
  .ireset  (ireset),
  .busy    (busy),
  .out_val (out_val)
);

/* tb.f */
logic/ldpc_code_pkg.sv
logic/ldpc_dec_pkg.sv
logic/ldpc_dec_ctrl.sv
logic/ldpc_dec_node_mem.sv
logic/ldpc_dec_cnode.sv
logic/ldpc_dec_out.sv
logic/ldpc_dec_top.sv
sim/ldpc_dec_tb_assert.sv
sim/ldpc_dec_tb.sv
